// ==== hw/cache_pkg.sv ====
package cache_pkg;

    // ------------------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        IDLE,
        SEND_WRITE_REQ,
        SEND_WRITE_DATA,
        WAIT_WRITE_RESP,
        SEND_READ_REQ,
        RECEIVE_READ_DATA
    } cache_state_t;

    // ------------------------------------------------------------------------
    // Word level types
    // ------------------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // Byte offset bits inside one 32-bit word
    localparam int ADDR_LSB = 2;

    // Fixed burst format on the memory side
    // 4-byte beats
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
    // Incrementing addresses
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

endpackage

// ==== hw/line_if.sv ====
interface line_if #(
    parameter int LINE_WORDS = 128
);

    // Index and tag widths follow the block size
    localparam int IDX_W = $clog2(LINE_WORDS);
    localparam int TAG_W = 32 - IDX_W - cache_pkg::ADDR_LSB;

    // Burst side, owned by the controller
    logic [IDX_W-1:0]    word_ptr;
    logic                fill_en;
    logic                fill_done;
    cache_pkg::word_t    fill_data;

    // Block side, owned by the store
    cache_pkg::word_t    evict_data;
    logic [TAG_W-1:0]    block_tag;
    logic                dirty;

    modport ctrl (
        output word_ptr,
        output fill_en,
        output fill_done,
        output fill_data,
        input  evict_data,
        input  block_tag,
        input  dirty
    );

    modport store (
        input  word_ptr,
        input  fill_en,
        input  fill_done,
        input  fill_data,
        output evict_data,
        output block_tag,
        output dirty
    );

endinterface

// ==== hw/cache_store.sv ====
module cache_store #(
    parameter int  LINE_WORDS = 128,
    localparam int IDX_W      = $clog2(LINE_WORDS),
    localparam int TAG_W      = 32 - IDX_W - cache_pkg::ADDR_LSB
) (
    input  logic             clk,
    input  logic             rst_n,
    line_if.store            line,
    input  logic [IDX_W-1:0] index,
    input  logic [TAG_W-1:0] req_tag,
    input  cache_pkg::word_t write_data,
    input  cache_pkg::strb_t byte_enable,
    input  logic             cpu_write,
    output logic             valid,
    output cache_pkg::word_t read_data
);

    // ------------------------------------------------------------------------
    // Block storage
    // ------------------------------------------------------------------------
    // One direct-mapped block, one tag for all words
    cache_pkg::word_t data_mem [LINE_WORDS];
    logic [TAG_W-1:0] tag_q;
    logic             valid_q;
    logic             dirty_q;

    // Byte mask expanded from the enables
    cache_pkg::word_t byte_mask;
    cache_pkg::word_t merged_word;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            byte_mask[8*b +: 8] = {8{byte_enable[b]}};
        end
    end

    // Old bytes kept where the enable is low
    assign merged_word = (data_mem[index] & ~byte_mask) | (write_data & byte_mask);

    // The controller grants CPU writes only in IDLE, so they never meet a refill
    always_ff @(posedge clk) begin
        if (cpu_write) begin
            data_mem[index] <= merged_word;
        end else if (line.fill_en) begin
            data_mem[line.word_ptr] <= line.fill_data;
        end
    end

    // New tag comes in with the last refill beat
    always_ff @(posedge clk) begin
        if (line.fill_done) begin
            tag_q <= req_tag;
        end
    end

    // ------------------------------------------------------------------------
    // Block flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else if (line.fill_done) begin
            // Fresh copy of memory
            valid_q <= 1'b1;
            dirty_q <= 1'b0;
        end else if (cpu_write) begin
            dirty_q <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Read side, all combinational
    // ------------------------------------------------------------------------
    assign read_data       = data_mem[index];
    assign line.evict_data = data_mem[line.word_ptr];
    assign line.block_tag  = tag_q;
    assign line.dirty      = dirty_q;
    assign valid           = valid_q;

endmodule

// ==== hw/cache_ctrl.sv ====
module cache_ctrl #(
    parameter int  LINE_WORDS = 128,
    localparam int IDX_W      = $clog2(LINE_WORDS),
    localparam int TAG_W      = 32 - IDX_W - cache_pkg::ADDR_LSB
) (
    input  logic             clk,
    input  logic             rst_n,
    line_if.ctrl             line,
    input  logic             hit,
    input  logic             read_enable,
    input  logic             write_enable,
    input  cache_pkg::strb_t byte_enable,
    input  logic             flush_order,
    input  logic [TAG_W-1:0] req_tag,
    output logic             cache_stall,
    output logic             cpu_write,

    // Write address channel
    output logic             awvalid,
    input  logic             awready,
    output cache_pkg::word_t awaddr,
    output logic [7:0]       awlen,
    // Write data channel
    output logic             wvalid,
    input  logic             wready,
    output cache_pkg::word_t wdata,
    output logic             wlast,
    // Write response channel
    input  logic             bvalid,
    output logic             bready,
    // Read address channel
    output logic             arvalid,
    input  logic             arready,
    output cache_pkg::word_t araddr,
    output logic [7:0]       arlen,
    // Read data channel
    input  logic             rvalid,
    output logic             rready,
    input  cache_pkg::word_t rdata,
    input  logic             rlast
);

    localparam logic [IDX_W-1:0] LAST_PTR = IDX_W'(LINE_WORDS - 1);

    cache_pkg::cache_state_t state, next_state;
    logic [IDX_W-1:0]        ptr, next_ptr;
    logic                    flushing, next_flushing;

    // A write with no byte enabled is no request at all
    logic eff_write;
    logic miss;
    logic idle;

    assign eff_write = write_enable & (|byte_enable);
    // Exactly one request may start a block transaction
    assign miss      = ~hit & (read_enable ^ eff_write);
    assign idle      = (state == cache_pkg::IDLE);

    // ------------------------------------------------------------------------
    // CPU side
    // ------------------------------------------------------------------------
    assign cpu_write   = idle & hit & eff_write;
    // Stall rises combinationally in the request cycle
    assign cache_stall = ~idle | flush_order | miss;

    // ------------------------------------------------------------------------
    // State, pointer and flush flag
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= cache_pkg::IDLE;
            ptr      <= '0;
            flushing <= 1'b0;
        end else begin
            state    <= next_state;
            ptr      <= next_ptr;
            flushing <= next_flushing;
        end
    end

    always_comb begin
        next_state    = state;
        next_ptr      = ptr;
        next_flushing = flushing;

        case (state)
            cache_pkg::IDLE: begin
                next_ptr = '0;
                // Flush wins over a miss in the same cycle
                if (flush_order) begin
                    next_flushing = 1'b1;
                    next_state    = cache_pkg::SEND_WRITE_REQ;
                end else if (miss) begin
                    next_state = line.dirty ? cache_pkg::SEND_WRITE_REQ
                                            : cache_pkg::SEND_READ_REQ;
                end
            end
            cache_pkg::SEND_WRITE_REQ: begin
                if (awready) begin
                    next_state = cache_pkg::SEND_WRITE_DATA;
                end
            end
            cache_pkg::SEND_WRITE_DATA: begin
                // Pointer moves on accepted beats only
                if (wready) begin
                    next_ptr = ptr + 1'b1;
                    if (ptr == LAST_PTR) begin
                        next_state = cache_pkg::WAIT_WRITE_RESP;
                    end
                end
            end
            cache_pkg::WAIT_WRITE_RESP: begin
                // Any response code closes the write-back
                if (bvalid) begin
                    next_flushing = 1'b0;
                    next_state    = flushing ? cache_pkg::IDLE : cache_pkg::SEND_READ_REQ;
                end
            end
            cache_pkg::SEND_READ_REQ: begin
                next_ptr = '0;
                if (arready) begin
                    next_state = cache_pkg::RECEIVE_READ_DATA;
                end
            end
            cache_pkg::RECEIVE_READ_DATA: begin
                if (rvalid) begin
                    next_ptr = ptr + 1'b1;
                    if (rlast) begin
                        next_state = cache_pkg::IDLE;
                    end
                end
            end
            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // AXI signals, decoded from the state
    // ------------------------------------------------------------------------
    assign awvalid = (state == cache_pkg::SEND_WRITE_REQ);
    assign wvalid  = (state == cache_pkg::SEND_WRITE_DATA);
    assign bready  = (state == cache_pkg::WAIT_WRITE_RESP);
    assign arvalid = (state == cache_pkg::SEND_READ_REQ);
    assign rready  = (state == cache_pkg::RECEIVE_READ_DATA);

    // Block aligned bursts over the whole block
    assign awaddr = {line.block_tag, {(IDX_W + cache_pkg::ADDR_LSB){1'b0}}};
    assign araddr = {req_tag, {(IDX_W + cache_pkg::ADDR_LSB){1'b0}}};
    assign awlen  = 8'(LINE_WORDS - 1);
    assign arlen  = 8'(LINE_WORDS - 1);

    // Evicted word always presented at the pointer
    assign wdata = line.evict_data;
    assign wlast = wvalid & (ptr == LAST_PTR);

    // ------------------------------------------------------------------------
    // Refill path into the store
    // ------------------------------------------------------------------------
    assign line.word_ptr  = ptr;
    assign line.fill_data = rdata;
    assign line.fill_en   = rready & rvalid;
    assign line.fill_done = rready & rvalid & rlast;

endmodule

// ==== hw/data_cache_top.sv ====
module data_cache_top #(
    parameter int LINE_WORDS = 128
) (
    input  logic             clk,
    input  logic             rst_n,

    // CPU port
    input  cache_pkg::word_t address,
    input  cache_pkg::word_t write_data,
    input  logic             read_enable,
    input  logic             write_enable,
    input  cache_pkg::strb_t byte_enable,
    output cache_pkg::word_t read_data,
    output logic             cache_stall,

    // CSR flush request, one cycle pulse
    input  logic             flush_order,

    // AXI memory side
    output logic             awvalid,
    input  logic             awready,
    output cache_pkg::word_t awaddr,
    output logic [7:0]       awlen,
    output logic             wvalid,
    input  logic             wready,
    output cache_pkg::word_t wdata,
    output logic             wlast,
    input  logic             bvalid,
    output logic             bready,
    output logic             arvalid,
    input  logic             arready,
    output cache_pkg::word_t araddr,
    output logic [7:0]       arlen,
    input  logic             rvalid,
    output logic             rready,
    input  cache_pkg::word_t rdata,
    input  logic             rlast
);

    localparam int IDX_W = $clog2(LINE_WORDS);
    localparam int TAG_W = 32 - IDX_W - cache_pkg::ADDR_LSB;

    // ------------------------------------------------------------------------
    // Address split and hit decode
    // ------------------------------------------------------------------------
    // | tag | word index | byte offset |
    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_index;
    logic             valid;
    logic             hit;
    logic             cpu_write;

    line_if #(.LINE_WORDS(LINE_WORDS)) line ();

    assign req_tag   = address[31 -: TAG_W];
    assign req_index = address[cache_pkg::ADDR_LSB +: IDX_W];
    // Single block, so one compare decides the hit
    assign hit       = valid & (req_tag == line.block_tag);

    cache_store #(
        .LINE_WORDS(LINE_WORDS)
    ) u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .line        (line.store),
        .index       (req_index),
        .req_tag     (req_tag),
        .write_data  (write_data),
        .byte_enable (byte_enable),
        .cpu_write   (cpu_write),
        .valid       (valid),
        .read_data   (read_data)
    );

    cache_ctrl #(
        .LINE_WORDS(LINE_WORDS)
    ) u_ctrl (
        .clk (clk), .rst_n (rst_n),
        .line (line.ctrl),
        .hit (hit),
        .read_enable (read_enable), .write_enable (write_enable),
        .byte_enable (byte_enable), .flush_order (flush_order),
        .req_tag (req_tag),
        .cache_stall (cache_stall), .cpu_write (cpu_write),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awlen (awlen),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wlast (wlast),
        .bvalid (bvalid), .bready (bready),
        .arvalid (arvalid), .arready (arready), .araddr (araddr), .arlen (arlen),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rlast (rlast)
    );

endmodule

// ==== sim/axi_mem_model.sv ====
module axi_mem_model #(
    parameter int LINE_WORDS = 128,
    parameter int MEM_AW     = 12
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             awvalid,
    output logic             awready,
    input  cache_pkg::word_t awaddr,
    input  logic [7:0]       awlen,
    input  logic             wvalid,
    output logic             wready,
    input  cache_pkg::word_t wdata,
    input  logic             wlast,
    output logic             bvalid,
    input  logic             bready,
    input  logic             arvalid,
    output logic             arready,
    input  cache_pkg::word_t araddr,
    input  logic [7:0]       arlen,
    output logic             rvalid,
    input  logic             rready,
    output cache_pkg::word_t rdata,
    output logic             rlast
);

    localparam int MEM_WORDS  = 1 << MEM_AW;
    localparam int BEAT_BYTES = 1 << cache_pkg::AXI_SIZE_WORD;
    // Bursts must start on a block boundary
    localparam int ALIGN_BITS = $clog2(LINE_WORDS * BEAT_BYTES);
    localparam logic [7:0] BURST_LEN = 8'(LINE_WORDS - 1);
    // INCR moves one beat per transfer, FIXED would stay put
    localparam int ADDR_STEP  = (cache_pkg::AXI_BURST_INCR == 2'b01) ? BEAT_BYTES : 0;

    // Word array, visible to the testbench by hierarchy
    cache_pkg::word_t mem [MEM_WORDS];

    // Burst statistics
    int               read_bursts;
    int               write_bursts;
    int               bad_bursts;
    cache_pkg::word_t last_araddr;
    cache_pkg::word_t last_awaddr;
    logic [7:0]       last_arlen;

    integer           seed = 50;
    cache_pkg::word_t wr_addr;
    cache_pkg::word_t rd_addr;
    logic [8:0]       wr_left;
    logic [8:0]       rd_left;
    logic [8:0]       rd_after;

    // Pattern depends on the full word address
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= i ^ 32'h5A5A0000;
        end
    end

    assign rdata    = mem[rd_addr[MEM_AW+1:2]];
    assign rlast    = (rd_left == 9'd1);
    // Beats still owed once this cycle's handshake is done
    assign rd_after = (rvalid && rready) ? rd_left - 9'd1 : rd_left;

    // ------------------------------------------------------------------------
    // One process, so the random sequence has a fixed order
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            awready      <= 1'b0;
            wready       <= 1'b0;
            bvalid       <= 1'b0;
            arready      <= 1'b0;
            rvalid       <= 1'b0;
            wr_left      <= '0;
            rd_left      <= '0;
            read_bursts  <= 0;
            write_bursts <= 0;
            bad_bursts   <= 0;
        end else begin
            // Random back-pressure on every ready
            awready <= ($random(seed) & 3) != 0;
            wready  <= ($random(seed) & 3) != 0;
            arready <= ($random(seed) & 3) != 0;

            // Write address must be aligned, a full block and inside the array
            if (awvalid && awready) begin
                write_bursts <= write_bursts + 1;
                last_awaddr  <= awaddr;
                wr_addr      <= awaddr;
                wr_left      <= {1'b0, awlen} + 9'd1;
                if (awaddr[ALIGN_BITS-1:0] != '0 || awlen != BURST_LEN ||
                    awaddr[31:MEM_AW+2] != '0) begin
                    bad_bursts <= bad_bursts + 1;
                end
            end

            // Write data with wlast on the final beat only
            if (wvalid && wready) begin
                mem[wr_addr[MEM_AW+1:2]] <= wdata;
                wr_addr <= wr_addr + ADDR_STEP;
                wr_left <= wr_left - 9'd1;
                if (wr_left == '0 || wlast != (wr_left == 9'd1)) begin
                    bad_bursts <= bad_bursts + 1;
                end
                if (wr_left == 9'd1) begin
                    bvalid <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            // Read address
            if (arvalid && arready) begin
                read_bursts <= read_bursts + 1;
                last_araddr <= araddr;
                last_arlen  <= arlen;
                rd_addr     <= araddr;
                rd_left     <= {1'b0, arlen} + 9'd1;
                if (araddr[ALIGN_BITS-1:0] != '0 || arlen != BURST_LEN ||
                    araddr[31:MEM_AW+2] != '0) begin
                    bad_bursts <= bad_bursts + 1;
                end
            end

            // Read data held until accepted, with random gaps between beats
            if (rvalid && rready) begin
                rd_addr <= rd_addr + ADDR_STEP;
                rd_left <= rd_left - 9'd1;
            end
            if (!rvalid || rready) begin
                rvalid <= (rd_after != '0) && (($random(seed) & 3) != 0);
            end
        end
    end

endmodule

// ==== sim/tb_data_cache.sv ====
module tb_data_cache;

    localparam int LINE_WORDS = 128;
    localparam int MEM_AW     = 12;
    localparam int MAX_OPS    = 32;
    localparam int TIMEOUT    = 4000;

    // Operation kinds, first column of the trace
    localparam cache_pkg::word_t OP_READ     = 32'h0;
    localparam cache_pkg::word_t OP_WRITE    = 32'h1;
    localparam cache_pkg::word_t OP_FLUSH    = 32'h2;
    localparam cache_pkg::word_t OP_MEM      = 32'h3;
    localparam cache_pkg::word_t OP_RD_BURST = 32'h4;
    localparam cache_pkg::word_t OP_WR_BURST = 32'h5;
    localparam cache_pkg::word_t OP_END      = 32'hF;

    logic             clk;
    logic             rst_n;
    cache_pkg::word_t address;
    cache_pkg::word_t write_data;
    logic             read_enable;
    logic             write_enable;
    cache_pkg::strb_t byte_enable;
    logic             flush_order;
    cache_pkg::word_t read_data;
    logic             cache_stall;

    // AXI between the DUT and the memory model
    logic             awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic             arvalid, arready, rvalid, rready, rlast;
    cache_pkg::word_t awaddr, wdata, araddr, rdata;
    logic [7:0]       awlen, arlen;

    // Five words per operation
    cache_pkg::word_t trace [MAX_OPS*5];

    data_cache_top #(.LINE_WORDS(LINE_WORDS)) uut (
        .clk (clk), .rst_n (rst_n),
        .address (address), .write_data (write_data),
        .read_enable (read_enable), .write_enable (write_enable),
        .byte_enable (byte_enable), .read_data (read_data),
        .cache_stall (cache_stall), .flush_order (flush_order),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awlen (awlen),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wlast (wlast),
        .bvalid (bvalid), .bready (bready),
        .arvalid (arvalid), .arready (arready), .araddr (araddr), .arlen (arlen),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rlast (rlast)
    );

    axi_mem_model #(.LINE_WORDS(LINE_WORDS), .MEM_AW(MEM_AW)) mem_model (
        .clk (clk), .rst_n (rst_n),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awlen (awlen),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wlast (wlast),
        .bvalid (bvalid), .bready (bready),
        .arvalid (arvalid), .arready (arready), .araddr (araddr), .arlen (arlen),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rlast (rlast)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Failure reporting and checks
    // ------------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input cache_pkg::word_t expected,
                               input cache_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error %s: expected %08h, actual %08h",
                                name, expected, actual));
        end
    endtask

    // Stall sampled mid-cycle, where it is settled
    task automatic wait_stall_low(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (cache_stall) begin
            if (cycles == TIMEOUT) begin
                abort_run($sformatf("Timeout: cache_stall stayed high for %0d cycles in %s",
                                    TIMEOUT, name));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Trace sequencing
    // ------------------------------------------------------------------------
    initial begin
        int               op_idx;
        cache_pkg::word_t kind;
        cache_pkg::word_t addr;
        cache_pkg::word_t wdata_op;
        cache_pkg::word_t be_op;
        cache_pkg::word_t exp_val;
        string            name;

        rst_n        <= 1'b0;
        address      <= '0;
        write_data   <= '0;
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        byte_enable  <= '0;
        flush_order  <= 1'b0;
        $readmemh("sim/cache_trace.txt", trace);

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        op_idx = 0;
        while (op_idx < MAX_OPS && trace[5*op_idx] != OP_END) begin
            kind     = trace[5*op_idx];
            addr     = trace[5*op_idx+1];
            wdata_op = trace[5*op_idx+2];
            be_op    = trace[5*op_idx+3];
            exp_val  = trace[5*op_idx+4];
            name     = $sformatf("op %0d kind %0h addr %08h", op_idx, kind, addr);

            case (kind)
                OP_READ: begin
                    @(posedge clk);
                    address     <= addr;
                    read_enable <= 1'b1;
                    wait_stall_low(name);
                    check_value(name, exp_val, read_data);
                    @(posedge clk);
                    read_enable <= 1'b0;
                end
                OP_WRITE: begin
                    @(posedge clk);
                    address      <= addr;
                    write_data   <= wdata_op;
                    byte_enable  <= be_op[3:0];
                    write_enable <= 1'b1;
                    wait_stall_low(name);
                    // Word is stored on this edge
                    @(posedge clk);
                    write_enable <= 1'b0;
                    byte_enable  <= '0;
                end
                OP_FLUSH: begin
                    @(posedge clk);
                    flush_order <= 1'b1;
                    @(posedge clk);
                    flush_order <= 1'b0;
                    wait_stall_low(name);
                end
                OP_MEM: begin
                    @(negedge clk);
                    check_value(name, exp_val, mem_model.mem[addr[MEM_AW+1:2]]);
                end
                OP_RD_BURST: begin
                    check_value({name, " read bursts"}, exp_val, mem_model.read_bursts);
                    check_value({name, " araddr"}, addr, mem_model.last_araddr);
                    check_value({name, " arlen"}, 32'(LINE_WORDS - 1),
                                {24'd0, mem_model.last_arlen});
                    check_value({name, " bad bursts"}, 32'd0, mem_model.bad_bursts);
                end
                OP_WR_BURST: begin
                    check_value({name, " write bursts"}, exp_val, mem_model.write_bursts);
                    check_value({name, " awaddr"}, addr, mem_model.last_awaddr);
                    check_value({name, " bad bursts"}, 32'd0, mem_model.bad_bursts);
                end
                default: begin
                    abort_run($sformatf("Unknown operation kind %0h at op %0d", kind, op_idx));
                end
            endcase
            op_idx++;
        end

        check_value("memory model burst format", 32'd0, mem_model.bad_bursts);
        if (op_idx == MAX_OPS) begin
            abort_run("Trace has no end marker within its slots");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== all.f ====
hw/cache_pkg.sv
hw/line_if.sv
hw/cache_store.sv
hw/cache_ctrl.sv
hw/data_cache_top.sv
sim/axi_mem_model.sv
sim/tb_data_cache.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
    --top-module tb_data_cache \
    -f all.f \
    -o tb_data_cache

# A $fatal in the testbench gives a non-zero exit status here
./obj_dir/tb_data_cache

// ==== sim/cache_trace.txt ====
// kind addr wdata be expected, kind 0 read 1 write 2 flush 3 memory word
// 4 read bursts (addr = last araddr) 5 write bursts (addr = last awaddr) F end
0 00000010 00000000 0 5A5A0004
4 00000000 00000000 0 00000001
0 000001FC 00000000 0 5A5A007F
0 00000100 00000000 0 5A5A0040
4 00000000 00000000 0 00000001
1 00000020 11223344 5 00000000
0 00000020 00000000 0 5A220044
1 00000020 FFFFFFFF 0 00000000
0 00000020 00000000 0 5A220044
0 00000404 00000000 0 5A5A0101
0 000005FC 00000000 0 5A5A017F
3 00000020 00000000 0 5A220044
3 00000024 00000000 0 5A5A0009
5 00000000 00000000 0 00000001
4 00000400 00000000 0 00000002
1 00000408 CAFEF00D F 00000000
2 00000000 00000000 0 00000000
3 00000408 00000000 0 CAFEF00D
0 00000408 00000000 0 CAFEF00D
4 00000400 00000000 0 00000002
5 00000400 00000000 0 00000002
F 00000000 00000000 0 00000000
